/* common/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// width of data words and byte addresses on the bus
`define LSU_DATA_W 32

// register file has 32 entries
`define LSU_REG_AW 5

`define LSU_LANES 4             // byte lanes per bus word

// size of the memory model in words
`define LSU_TB_MEM_DEPTH 1024

`endif

/* common/lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_NONE,                                // no memory access
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_LL,
        OP_SC
    } mem_op_e;

    typedef struct packed {
        mem_op_e                  op;
        logic [`LSU_DATA_W-1:0]   addr;         // effective address
        logic [`LSU_DATA_W-1:0]   rt;           // store data
        logic [`LSU_REG_AW-1:0]   waddr;
        logic                     wreg;
        logic [`LSU_DATA_W-1:0]   wdata;        // alu result for non-memory ops
    } mem_req_t;

    typedef struct packed {
        logic                     wreg;
        logic [`LSU_REG_AW-1:0]   waddr;
        logic [`LSU_DATA_W-1:0]   wdata;
        logic                     addr_err;     // misaligned half or word
    } mem_res_t;

    // big-endian bus, so lane 0 sits in the top bits
    typedef union packed {
        logic [0:`LSU_LANES-1][7:0]      bytes;
        logic [0:`LSU_LANES/2-1][15:0]   halves;
    } bus_word_u;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0]   word_addr;
        logic [`LSU_LANES-1:0]    sel;          // msb is lane 0
        bus_word_u                wdata;
        logic                     is_load;
        logic                     is_store;
        logic                     misaligned;
    } access_t;

endpackage

/* lsu/store_align.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module store_align import lsu_pkg::*; (
    input  mem_op_e                  op_i,
    input  logic [`LSU_DATA_W-1:0]   addr_i,
    input  logic [`LSU_DATA_W-1:0]   rt_i,
    output access_t                  acc_o
);
    localparam int half_lanes = `LSU_LANES / 2;

    logic [1:0] offset;

    assign offset = addr_i[1:0];

    always_comb begin
        acc_o           = '0;
        acc_o.word_addr = {addr_i[`LSU_DATA_W-1:2], 2'b00};     // whole word, lanes pick the bytes
        acc_o.is_load   = op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LL};
        acc_o.is_store  = op_i inside {OP_SB, OP_SH, OP_SW, OP_SC};
        case (op_i)
            OP_LB, OP_LBU, OP_SB: begin
                // lane k counted from the msb lane
                acc_o.sel         = {1'b1, {(`LSU_LANES-1){1'b0}}} >> offset;
                acc_o.wdata.bytes = {`LSU_LANES{rt_i[7:0]}};    // low byte in every lane
            end
            OP_LH, OP_LHU, OP_SH: begin
                if (offset[1]) begin
                    acc_o.sel = {{half_lanes{1'b0}}, {half_lanes{1'b1}}};  // lower pair
                end else begin
                    acc_o.sel = {{half_lanes{1'b1}}, {half_lanes{1'b0}}};  // upper pair
                end
                acc_o.wdata.halves = {2{rt_i[15:0]}};
                acc_o.misaligned   = offset[0];
            end
            OP_LW, OP_LL, OP_SW, OP_SC: begin
                acc_o.sel        = '1;
                acc_o.wdata      = rt_i;
                acc_o.misaligned = |offset;
            end
            default: begin
                acc_o.sel = '0;                                 // op_none, no lanes
            end
        endcase
    end

endmodule

/* lsu/load_align.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module load_align import lsu_pkg::*; (
    input  mem_op_e                  op_i,
    input  logic [1:0]               offset_i,
    input  bus_word_u                rdata_i,
    output logic [`LSU_DATA_W-1:0]   value_o
);
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign lane_byte = rdata_i.bytes[offset_i];         // offset 0 is the top byte
    assign lane_half = rdata_i.halves[offset_i[1]];

    always_comb begin
        case (op_i)
            OP_LB: begin
                value_o = {{(`LSU_DATA_W-8){lane_byte[7]}}, lane_byte};
            end
            OP_LBU: begin
                value_o = {{(`LSU_DATA_W-8){1'b0}}, lane_byte};
            end
            OP_LH: begin
                value_o = {{(`LSU_DATA_W-16){lane_half[15]}}, lane_half};
            end
            OP_LHU: begin
                value_o = {{(`LSU_DATA_W-16){1'b0}}, lane_half};
            end
            default: begin
                value_o = rdata_i;                      // lw and ll take the whole word
            end
        endcase
    end

endmodule

/* lsu/lsu_ctrl.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module lsu_ctrl import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     req_valid_i,
    input  mem_req_t                 req_i,
    output logic                     req_ready_o,
    output mem_op_e                  op_o,
    output logic [`LSU_DATA_W-1:0]   addr_o,
    output logic [`LSU_DATA_W-1:0]   rt_o,
    input  access_t                  acc_i,
    output logic                     start_o,
    input  logic                     done_i,
    input  logic [`LSU_DATA_W-1:0]   load_value_i,
    output logic                     res_valid_o,
    output mem_res_t                 res_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_BUS
    } state_e;

    state_e   state_q;
    mem_req_t req_q;
    mem_res_t res_q;
    logic     res_valid_q;
    logic     load_q;           // wdata taken from the bus word
    logic     link_q;
    logic     bus_go;

    assign req_ready_o = (state_q == ST_IDLE);
    assign op_o        = req_q.op;
    assign addr_o      = req_q.addr;
    assign rt_o        = req_q.rt;

    // an sc only goes out while the link bit is still set
    assign bus_go  = !acc_i.misaligned &&
                     (acc_i.is_load || (acc_i.is_store && (req_q.op != OP_SC || link_q)));
    assign start_o = (state_q == ST_DECIDE) && bus_go;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    state_q <= bus_go ? ST_BUS : ST_IDLE;
                end
                ST_BUS: begin
                    if (done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

    // result known by the end of the decide cycle, except load data
    always_ff @(posedge clk_i) begin
        if (state_q == ST_DECIDE) begin
            res_q.waddr    <= req_q.waddr;
            res_q.addr_err <= acc_i.misaligned;
            res_q.wreg     <= 1'b0;
            res_q.wdata    <= '0;
            if (!acc_i.misaligned) begin
                if (req_q.op == OP_SC) begin
                    res_q.wreg  <= 1'b1;
                    res_q.wdata <= {{(`LSU_DATA_W-1){1'b0}}, link_q};  // 1 on success
                end else if (acc_i.is_load) begin
                    res_q.wreg <= 1'b1;
                end else if (!acc_i.is_store) begin
                    res_q.wreg  <= req_q.wreg;                      // op_none passes through
                    res_q.wdata <= req_q.wdata;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_q <= 1'b0;
            load_q      <= 1'b0;
            link_q      <= 1'b0;
        end else begin
            res_valid_q <= (state_q == ST_DECIDE) && !bus_go;
            if (state_q == ST_DECIDE) begin
                load_q <= bus_go && acc_i.is_load;
            end
            if (state_q == ST_DECIDE && req_q.op == OP_SC) begin
                link_q <= 1'b0;                                     // any sc drops the link
            end else if (done_i && req_q.op == OP_LL) begin
                link_q <= 1'b1;
            end
        end
    end

    // bus results leave with done, load data from the captured bus word
    always_comb begin
        res_o = res_q;
        if (load_q) begin
            res_o.wdata = load_value_i;
        end
    end

    assign res_valid_o = res_valid_q | done_i;

endmodule

/* design/wb_data_master.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module wb_data_master import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  access_t                  acc_i,
    output logic                     done_o,
    output bus_word_u                rdata_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [`LSU_DATA_W-1:0]   wb_adr_o,
    output logic [`LSU_LANES-1:0]    wb_sel_o,
    output logic [`LSU_DATA_W-1:0]   wb_dat_o,
    input  logic [`LSU_DATA_W-1:0]   wb_dat_i,
    input  logic                     wb_ack_i
);
    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e                  state_q;
    logic                    we_q;
    logic                    done_q;
    logic [`LSU_DATA_W-1:0]  adr_q;
    logic [`LSU_LANES-1:0]   sel_q;
    bus_word_u               dat_q;
    bus_word_u               rdata_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            we_q    <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;                             // single cycle pulse
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_BUSY;
                        we_q    <= acc_i.is_store;
                    end
                end
                ST_BUSY: begin
                    if (wb_ack_i) begin
                        state_q <= ST_IDLE;             // cyc and stb drop here
                        we_q    <= 1'b0;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // address, select and data stay put until ack
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            adr_q <= acc_i.word_addr;
            sel_q <= acc_i.sel;
            dat_q <= acc_i.wdata;
        end
        if (state_q == ST_BUSY && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o = (state_q == ST_BUSY);
    assign wb_stb_o = (state_q == ST_BUSY);
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_sel_o = sel_q;
    assign wb_dat_o = dat_q;
    assign done_o   = done_q;
    assign rdata_o  = rdata_q;

endmodule

/* design/mem_stage_top.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module mem_stage_top import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     req_valid_i,
    input  mem_req_t                 req_i,
    output logic                     req_ready_o,
    output logic                     res_valid_o,
    output mem_res_t                 res_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [`LSU_DATA_W-1:0]   wb_adr_o,
    output logic [`LSU_LANES-1:0]    wb_sel_o,
    output logic [`LSU_DATA_W-1:0]   wb_dat_o,
    input  logic [`LSU_DATA_W-1:0]   wb_dat_i,
    input  logic                     wb_ack_i
);
    mem_op_e                 op;
    logic [`LSU_DATA_W-1:0]  addr;
    logic [`LSU_DATA_W-1:0]  rt;
    access_t                 acc;
    logic                    start;
    logic                    done;
    bus_word_u               rdata;
    logic [`LSU_DATA_W-1:0]  load_value;

    lsu_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .op_o         (op),
        .addr_o       (addr),
        .rt_o         (rt),
        .acc_i        (acc),
        .start_o      (start),
        .done_i       (done),
        .load_value_i (load_value),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

    store_align u_store_align (
        .op_i   (op),
        .addr_i (addr),
        .rt_i   (rt),
        .acc_o  (acc)
    );

    load_align u_load_align (
        .op_i     (op),
        .offset_i (addr[1:0]),
        .rdata_i  (rdata),
        .value_o  (load_value)
    );

    wb_data_master u_wb_master (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start),
        .acc_i    (acc),
        .done_o   (done),
        .rdata_o  (rdata),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule

/* sim/wb_ram_model.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module wb_ram_model #(
    parameter logic [31:0] seed_init = 32'he585_fa1a
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cyc_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [`LSU_DATA_W-1:0]   adr_i,
    input  logic [`LSU_LANES-1:0]    sel_i,
    input  logic [`LSU_DATA_W-1:0]   dat_i,
    output logic [`LSU_DATA_W-1:0]   dat_o,
    output logic                     ack_o
);
    localparam int aw = $clog2(`LSU_TB_MEM_DEPTH);

    logic [`LSU_DATA_W-1:0] mem [0:`LSU_TB_MEM_DEPTH-1];     // filled by the testbench
    logic [1:0]             wait_q;         // wait states left before the next ack
    logic [aw-1:0]          idx;
    integer                 seed;

    initial begin
        seed = seed_init;
    end

    assign idx = adr_i[aw+1:2];

    always @(posedge clk_i) begin
        if (rst_i) begin
            ack_o  <= 1'b0;
            wait_q <= '0;
            dat_o  <= '0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o) begin
                if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    ack_o  <= 1'b1;
                    dat_o  <= mem[idx];
                    wait_q <= 2'($random(seed));            // 0 to 3 wait states next time
                    if (we_i) begin
                        // sel msb is lane 0 which is the top byte
                        for (int l = 0; l < `LSU_LANES; l++) begin
                            if (sel_i[`LSU_LANES-1-l]) begin
                                mem[idx][`LSU_DATA_W-1-8*l -: 8] <= dat_i[`LSU_DATA_W-1-8*l -: 8];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

/* sim/mem_stage_asserts.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module mem_stage_asserts (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     req_ready_i,
    input  logic                     res_valid_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`LSU_DATA_W-1:0]   wb_adr_i,
    input  logic [`LSU_LANES-1:0]    wb_sel_i,
    input  logic [`LSU_DATA_W-1:0]   wb_wdat_i,
    input  logic                     wb_ack_i
);
    int unsigned fired;         // read by the testbench at the end

    initial begin
        fired = 0;
    end

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_stb_i |-> wb_cyc_i)
        else begin
            $error("wishbone stb high while cyc is low");
            fired++;
        end

    // master holds the request until the slave answers
    bus_held: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i) && $stable(wb_sel_i) &&
                                  $stable(wb_wdat_i) && $stable(wb_we_i))
        else begin
            $error("wishbone request changed before ack");
            fired++;
        end

    res_single: assert property (@(posedge clk_i) disable iff (rst_i)
        res_valid_i |=> !res_valid_i)
        else begin
            $error("result valid held longer than one cycle");
            fired++;
        end

    busy_not_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_cyc_i |-> !req_ready_i)
        else begin
            $error("stage ready while a bus cycle is open");
            fired++;
        end

endmodule

bind mem_stage_top mem_stage_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_ready_i (req_ready_o),
    .res_valid_i (res_valid_o),
    .wb_cyc_i    (wb_cyc_o),
    .wb_stb_i    (wb_stb_o),
    .wb_we_i     (wb_we_o),
    .wb_adr_i    (wb_adr_o),
    .wb_sel_i    (wb_sel_o),
    .wb_wdat_i   (wb_dat_o),
    .wb_ack_i    (wb_ack_i)
);

/* sim/tb_mem_stage.sv */
`timescale 1ns/10ps

`include "lsu_cfg.svh"

module tb_mem_stage import lsu_pkg::*; ();
    localparam int random_ops   = 200;
    localparam int directed_ops = 80;       // upper bound over the directed tests
    localparam int worst_cycles = 12;       // one op with three wait states plus slack
    localparam int drain_cycles = 50;
    localparam int mem_aw       = $clog2(`LSU_TB_MEM_DEPTH);

    typedef struct packed {
        mem_res_t    res;
        logic        check_data;            // wdata only matters when written
        logic [31:0] bus_count;             // acks expected by this result
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    mem_req_t                req;
    logic                    req_ready;
    logic                    res_valid;
    mem_res_t                res;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`LSU_DATA_W-1:0]  wb_adr;
    logic [`LSU_LANES-1:0]   wb_sel;
    logic [`LSU_DATA_W-1:0]  wb_dat_w;
    logic [`LSU_DATA_W-1:0]  wb_dat_r;
    logic                    wb_ack;

    logic [`LSU_DATA_W-1:0]  shadow_mem [0:`LSU_TB_MEM_DEPTH-1];
    logic                    shadow_link;
    expect_t                 exp_q[$];
    expect_t                 exp_e;
    mem_res_t                got;
    int unsigned             bus_seen;
    int unsigned             bus_expect;
    int unsigned             op_count;
    integer                  seed;
    string                   cur_test;
    int                      test_checks;
    int                      test_errors;
    int                      total_checks;
    int                      total_errors;
    int                      tests_run;

    mem_stage_top DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .res_valid_o (res_valid),
        .res_o       (res),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_sel_o    (wb_sel),
        .wb_dat_o    (wb_dat_w),
        .wb_dat_i    (wb_dat_r),
        .wb_ack_i    (wb_ack)
    );

    wb_ram_model u_ram (
        .clk_i (clk),
        .rst_i (rst),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .sel_i (wb_sel),
        .dat_i (wb_dat_w),
        .dat_o (wb_dat_r),
        .ack_o (wb_ack)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] fill_word(input int idx);
        return {idx[15:0] ^ 16'hc35a, idx[15:0] * 16'h02f1 + 16'h0b7e};
    endfunction

    // expected writeback result plus the shadow memory and link bit update
    function automatic mem_res_t predict(input mem_req_t r, output logic bus_used);
        mem_res_t    p;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        int          idx;
        int          sh_b;
        int          sh_h;
        p        = '0;
        p.waddr  = r.waddr;
        bus_used = 1'b0;
        idx      = r.addr[mem_aw+1:2];
        sh_b     = 8 * (3 - r.addr[1:0]);           // offset 0 is the top byte
        sh_h     = r.addr[1] ? 0 : 16;
        word     = shadow_mem[idx];
        b        = word >> sh_b;
        h        = word >> sh_h;
        case (r.op)
            OP_NONE: begin
                p.wreg  = r.wreg;
                p.wdata = r.wdata;
            end
            OP_LB, OP_LBU: begin
                bus_used = 1'b1;
                p.wreg   = 1'b1;
                p.wdata  = (r.op == OP_LB) ? {{24{b[7]}}, b} : {24'h0, b};
            end
            OP_LH, OP_LHU: begin
                if (r.addr[0]) begin
                    p.addr_err = 1'b1;
                end else begin
                    bus_used = 1'b1;
                    p.wreg   = 1'b1;
                    p.wdata  = (r.op == OP_LH) ? {{16{h[15]}}, h} : {16'h0, h};
                end
            end
            OP_LW, OP_LL: begin
                if (r.addr[1:0] != 2'd0) begin
                    p.addr_err = 1'b1;
                end else begin
                    bus_used = 1'b1;
                    p.wreg   = 1'b1;
                    p.wdata  = word;
                    if (r.op == OP_LL) begin
                        shadow_link = 1'b1;
                    end
                end
            end
            OP_SB: begin
                bus_used = 1'b1;
                word     = (word & ~(32'hff << sh_b)) | ({24'h0, r.rt[7:0]} << sh_b);
            end
            OP_SH: begin
                if (r.addr[0]) begin
                    p.addr_err = 1'b1;
                end else begin
                    bus_used = 1'b1;
                    word     = (word & ~(32'hffff << sh_h)) | ({16'h0, r.rt[15:0]} << sh_h);
                end
            end
            OP_SW: begin
                if (r.addr[1:0] != 2'd0) begin
                    p.addr_err = 1'b1;
                end else begin
                    bus_used = 1'b1;
                    word     = r.rt;
                end
            end
            OP_SC: begin
                if (r.addr[1:0] != 2'd0) begin
                    p.addr_err = 1'b1;
                end else begin
                    p.wreg  = 1'b1;
                    p.wdata = {31'h0, shadow_link};
                    if (shadow_link) begin
                        bus_used = 1'b1;
                        word     = r.rt;
                    end
                end
                shadow_link = 1'b0;                 // every sc drops the link
            end
            default: begin
            end
        endcase
        shadow_mem[idx] = word;
        return p;
    endfunction

    task automatic send_req(input mem_req_t r);
        expect_t e;
        logic    bus_used;
        e.res        = predict(r, bus_used);
        e.check_data = e.res.wreg || (r.op == OP_NONE);
        if (bus_used) begin
            bus_expect++;
        end
        e.bus_count = bus_expect;
        exp_q.push_back(e);
        op_count++;
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                             // accepted on this edge
        #2;
        req_valid = 1'b0;
    endtask

    task automatic run_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] rt);
        mem_req_t r;
        r       = '0;
        r.op    = op;
        r.addr  = addr;
        r.rt    = rt;
        r.waddr = op_count[4:0];
        send_req(r);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d results never came back", cur_test, exp_q.size());
            test_errors += exp_q.size();
            exp_q.delete();
        end
        $display("test %-10s %0d results checked, %0d errors", cur_test, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
        @(posedge clk);
        #2;
    endtask

    // counts acks and checks each writeback pulse in order
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_cyc && wb_stb && wb_ack) begin
                bus_seen++;
            end
            if (res_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: result pulse with no request outstanding", cur_test);
                    test_errors++;
                end else begin
                    exp_e = exp_q.pop_front();
                    got   = res;
                    test_checks++;
                    assert (got.wreg === exp_e.res.wreg && got.waddr === exp_e.res.waddr &&
                            got.addr_err === exp_e.res.addr_err &&
                            (!exp_e.check_data || got.wdata === exp_e.res.wdata))
                    else begin
                        $display("[FAIL] %s: expected %h actual %h", cur_test, exp_e.res, got);
                        test_errors++;
                    end
                    assert (bus_seen == exp_e.bus_count)
                    else begin
                        $display("[FAIL] %s: bus cycles expected %0d actual %0d",
                                 cur_test, exp_e.bus_count, bus_seen);
                        test_errors++;
                    end
                end
            end
        end
    end

    initial begin
        repeat ((directed_ops + random_ops) * worst_cycles + 100) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        mem_req_t r;
        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        seed         = 32'he585_fa1a;
        shadow_link  = 1'b0;
        bus_seen     = 0;
        bus_expect   = 0;
        op_count     = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        for (int i = 0; i < `LSU_TB_MEM_DEPTH; i++) begin
            shadow_mem[i] = fill_word(i);
            u_ram.mem[i]  = fill_word(i);
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("sw_lw");
        run_op(OP_SW, 32'h40, 32'hdead_beef);
        run_op(OP_LW, 32'h40, 32'h0);
        run_op(OP_SW, 32'h44, 32'h1234_5678);
        run_op(OP_LW, 32'h44, 32'h0);
        run_op(OP_LW, 32'h40, 32'h0);
        end_test();

        start_test("sub_word");
        for (int k = 0; k < 4; k++) begin
            run_op(OP_SB, 32'h80 + k, 32'h0000_0a85 + 32'h31 * k);  // both sign polarities
        end
        for (int k = 0; k < 4; k++) begin
            run_op(OP_LB, 32'h80 + k, 32'h0);
            run_op(OP_LBU, 32'h80 + k, 32'h0);
        end
        run_op(OP_LW, 32'h80, 32'h0);
        run_op(OP_SB, 32'ha1, 32'h77);              // one lane of a filled word
        run_op(OP_LW, 32'ha0, 32'h0);
        run_op(OP_SH, 32'h90, 32'h0001_9abc);
        run_op(OP_SH, 32'h96, 32'hffff_4321);
        for (int k = 0; k < 4; k += 2) begin
            run_op(OP_LH, 32'h90 + k, 32'h0);
            run_op(OP_LHU, 32'h90 + k, 32'h0);
            run_op(OP_LH, 32'h94 + k, 32'h0);
            run_op(OP_LHU, 32'h94 + k, 32'h0);
        end
        run_op(OP_LW, 32'h90, 32'h0);
        run_op(OP_LW, 32'h94, 32'h0);
        end_test();

        start_test("misaligned");
        run_op(OP_SW, 32'hc0, 32'h1122_3344);
        run_op(OP_LH, 32'hc1, 32'h0);
        run_op(OP_LHU, 32'hc3, 32'h0);
        run_op(OP_SH, 32'hc1, 32'hffff_ffff);
        run_op(OP_LW, 32'hc2, 32'h0);
        run_op(OP_SW, 32'hc3, 32'h0);
        run_op(OP_LL, 32'hc1, 32'h0);
        run_op(OP_SC, 32'hc2, 32'h0);
        run_op(OP_LW, 32'hc0, 32'h0);
        end_test();

        start_test("ll_sc");
        run_op(OP_SW, 32'hd0, 32'h0);
        run_op(OP_LL, 32'hd0, 32'h0);
        run_op(OP_SC, 32'hd0, 32'hcafe_f00d);
        run_op(OP_LW, 32'hd0, 32'h0);
        run_op(OP_SC, 32'hd0, 32'h55);              // link already gone
        run_op(OP_LW, 32'hd0, 32'h0);
        run_op(OP_SC, 32'hd4, 32'h66);
        run_op(OP_LW, 32'hd4, 32'h0);
        end_test();

        start_test("op_none");
        for (int k = 0; k < 6; k++) begin
            r       = '0;
            r.op    = OP_NONE;
            r.addr  = 32'h1357 * k + 1;
            r.waddr = 5'(k * 5 + 3);
            r.wreg  = k[0];
            r.wdata = 32'ha5a5_0000 + k;
            send_req(r);
        end
        end_test();

        start_test("random");
        for (int n = 0; n < random_ops; n++) begin
            r       = '0;
            r.op    = mem_op_e'($unsigned($random(seed)) % 11);
            r.addr  = $random(seed) & 32'h7f;       // 32 words so ll and sc collide
            r.rt    = $random(seed);
            r.waddr = 5'($random(seed));
            r.wreg  = 1'($random(seed));
            r.wdata = $random(seed);
            send_req(r);
        end
        end_test();

        if (DUT.u_asserts.fired != 0) begin
            $display("bus and handshake assertions failed %0d times", DUT.u_asserts.fired);
        end
        $display("%0d tests, %0d results checked, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0 && DUT.u_asserts.fired == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/lsu_pkg.sv
lsu/store_align.sv
lsu/load_align.sv
lsu/lsu_ctrl.sv
design/wb_data_master.sv
design/mem_stage_top.sv
sim/wb_ram_model.sv
sim/mem_stage_asserts.sv
sim/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - lsu/store_align.sv
      - lsu/load_align.sv
      - lsu/lsu_ctrl.sv
      - design/wb_data_master.sv
      - design/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/wb_ram_model.sv
      - sim/mem_stage_asserts.sv
      - sim/tb_mem_stage.sv
